// ==== build.f ====
source/spi_pkg.sv
source/spi_clk_gen.sv
source/spi_master.sv
source/spi_frame_ctrl.sv
source/conv_spi_top.sv
test/tb_clk_gen.sv
test/tb_conv_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
	--top-module tb_conv_spi -f build.f -o tb_conv_spi \
	&& ./obj_dir/tb_conv_spi | tee sim.log \
	|| echo "build or simulation error"
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== source/conv_spi_top.sv ====
`timescale 1ns/10ps

module conv_spi_top import spi_pkg::*; (
	input logic CLK50MHZ,
	input logic RST,
	// request side
	input logic req_valid,
	input conv_req_t req,
	output logic busy,
	output logic result_valid,
	output conv_result_t result,
	// converter pins
	output logic spi_sck,
	output logic spi_cs,
	output logic spi_mosi,
	input logic spi_miso
);

	// clock generator strobes
	logic sck_level;
	logic half_trig;
	logic bit_trig;

	// controller to master
	logic spi_trig;
	logic spi_done;
	spi_word_u tx_word;
	spi_word_u rx_word;

	//////////////////////////////
	// serial clock source
	//////////////////////////////
	spi_clk_gen u_clk_gen (
		.CLK50MHZ (CLK50MHZ),
		.RST (RST),
		.sck_level (sck_level),
		.half_trig (half_trig),
		.bit_trig (bit_trig)
	);

	//////////////////////////////
	// request to frame
	//////////////////////////////
	spi_frame_ctrl u_frame_ctrl (
		.CLK50MHZ (CLK50MHZ),
		.RST (RST),
		.req_valid (req_valid),
		.req (req),
		.busy (busy),
		.result_valid (result_valid),
		.result (result),
		.spi_trig (spi_trig),
		.tx_word (tx_word),
		.spi_done (spi_done),
		.rx_word (rx_word)
	);

	// shift engine on the pins
	spi_master u_master (
		.CLK50MHZ (CLK50MHZ),
		.RST (RST),
		.sck_level (sck_level),
		.half_trig (half_trig),
		.bit_trig (bit_trig),
		.spi_trig (spi_trig),
		.tx_word (tx_word),
		.rx_word (rx_word),
		.spi_done (spi_done),
		.spi_sck (spi_sck),
		.spi_cs (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

endmodule

// ==== source/spi_clk_gen.sv ====
`timescale 1ns/10ps

module spi_clk_gen import spi_pkg::*; (
	input logic CLK50MHZ,
	input logic RST,
	output logic sck_level,
	output logic half_trig,
	output logic bit_trig
);

	// cycles spent in the current half period
	logic [SCK_CNT_W-1:0] half_cnt;
	logic half_end;

	// last cycle of a half period
	assign half_end = (half_cnt == SCK_CNT_W'(SCK_HALF_CYCLES - 1));

	//////////////////////////////
	// half period counter
	//////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			half_cnt <= '0;
		end else if (half_end) begin
			half_cnt <= '0;
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// level and strobes
	//////////////////////////////
	// strobes are registered with the toggle,
	// so they sit in the first cycle of the new level
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			sck_level <= 1'b0;
			half_trig <= 1'b0;
			bit_trig <= 1'b0;
		end else begin
			half_trig <= half_end;
			// falling change only, data moves here
			bit_trig <= half_end & sck_level;
			if (half_end) begin
				sck_level <= ~sck_level;
			end
		end
	end

	// every bit strobe is also a half strobe
	a_bit_in_half: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		bit_trig |-> half_trig && !sck_level
	) else $error("bit_trig without falling half_trig");

endmodule

// ==== source/spi_frame_ctrl.sv ====
`timescale 1ns/10ps

module spi_frame_ctrl import spi_pkg::*; (
	input logic CLK50MHZ,
	input logic RST,
	// user side
	input logic req_valid,
	input conv_req_t req,
	output logic busy,
	output logic result_valid,
	output conv_result_t result,
	// master side
	output logic spi_trig,
	output spi_word_u tx_word,
	input logic spi_done,
	input spi_word_u rx_word
);

	logic [1:0] state;
	// request kept for the whole frame
	conv_req_t req_q;

	//////////////////////////////
	// state machine and trigger
	//////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= C_IDLE;
			spi_trig <= 1'b0;
		end else begin
			// one cycle pulse unless set below
			spi_trig <= 1'b0;
			case (state)
				C_IDLE: begin
					// requests while busy are dropped
					if (req_valid) begin
						state <= C_RUN;
						spi_trig <= 1'b1;
					end
				end
				C_RUN: begin
					if (spi_done) begin
						state <= C_REPORT;
					end
				end
				C_REPORT: begin
					state <= C_IDLE;
				end
				default: begin
					state <= C_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (state == C_IDLE && req_valid) begin
			req_q <= req;
		end
	end

	// command view, stable from req_q during the trigger
	always_comb begin
		tx_word.cmd.op = req_q.write ? OP_WRITE : OP_READ;
		tx_word.cmd.channel = {2'b00, req_q.channel};
		tx_word.cmd.code = req_q.code;
		tx_word.cmd.pad = 8'h00;
	end

	//////////////////////////////
	// reply decode
	//////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (state == C_RUN && spi_done) begin
			result.channel <= rx_word.reply.channel;
			result.sample <= rx_word.reply.sample;
			result.status <= rx_word.reply.status;
			result.chan_match <= (rx_word.reply.channel == {2'b00, req_q.channel});
			result.was_write <= req_q.write;
		end
	end

	// busy from the cycle after the request through the report
	assign busy = (state != C_IDLE);
	assign result_valid = (state == C_REPORT);

	// master only finishes frames this block started
	a_done_not_idle: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		spi_done |-> (state != C_IDLE)
	) else $error("spi_done while idle");

endmodule

// ==== source/spi_master.sv ====
`timescale 1ns/10ps

module spi_master import spi_pkg::*; (
	input logic CLK50MHZ,
	input logic RST,
	// strobes from the clock generator
	input logic sck_level,
	input logic half_trig,
	input logic bit_trig,
	// frame handshake
	input logic spi_trig,
	input spi_word_u tx_word,
	output spi_word_u rx_word,
	output logic spi_done,
	// pins
	output logic spi_sck,
	output logic spi_cs,
	output logic spi_mosi,
	input logic spi_miso
);

	logic [1:0] state;
	logic [SPI_WIDTH-1:0] shift_reg;
	logic [SPI_IDX_W-1:0] bit_idx;
	logic last_bit;
	logic spi_clocking;
	logic sck_en;

	// strobe that ends the frame
	assign last_bit = (bit_idx == SPI_IDX_W'(SPI_WIDTH));

	//////////////////////////////
	// state machine
	//////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= M_WAIT;
		end else begin
			case (state)
				M_WAIT: begin
					if (spi_trig) begin
						state <= M_SEND;
					end
				end
				M_SEND: begin
					if (bit_trig && last_bit) begin
						state <= M_DONE;
					end
				end
				// single cycle, gives the done pulse
				M_DONE: begin
					state <= M_WAIT;
				end
				default: begin
					state <= M_WAIT;
				end
			endcase
		end
	end

	// bit counter, one step per strobe, parked on the last one
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_idx <= '0;
		end else if (state == M_WAIT) begin
			bit_idx <= '0;
		end else if (state == M_SEND && bit_trig && !last_bit) begin
			bit_idx <= bit_idx + 1'b1;
		end
	end

	//////////////////////////////
	// shift register
	//////////////////////////////
	// tx word taken with the trigger, miso enters at the bottom;
	// the first strobe shifts in a dummy that falls out by the end
	always_ff @(posedge CLK50MHZ) begin
		if (state == M_WAIT && spi_trig) begin
			shift_reg <= tx_word;
		end else if (state == M_SEND && bit_trig) begin
			shift_reg <= {shift_reg[SPI_WIDTH-2:0], spi_miso};
		end
	end

	// reply held until the next trigger
	assign rx_word = shift_reg;
	assign spi_done = (state == M_DONE);

	//////////////////////////////
	// chip select and mosi
	//////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs <= 1'b1;
			spi_mosi <= 1'b0;
		end else begin
			case (state)
				M_WAIT: begin
					spi_cs <= 1'b1;
					spi_mosi <= 1'b0;
				end
				M_SEND: begin
					if (bit_trig) begin
						// low from the first strobe, high on the last
						spi_cs <= last_bit;
						// park mosi low once the word is out
						spi_mosi <= last_bit ? 1'b0 : shift_reg[SPI_WIDTH-1];
					end
				end
				default: begin
					spi_cs <= spi_cs;
				end
			endcase
		end
	end

	//////////////////////////////
	// serial clock gating
	//////////////////////////////
	// armed during the frame, dropped at the next half period after cs rises
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_clocking <= 1'b0;
		end else if (!spi_cs) begin
			spi_clocking <= 1'b1;
		end else if (half_trig) begin
			spi_clocking <= 1'b0;
		end
	end

	// free running sck when gating is off
	assign sck_en = SCK_GATED ? ~spi_cs : 1'b1;
	assign spi_sck = sck_level & sck_en;

	// no frame outside the send state
	a_cs_idle: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		(state == M_WAIT) |-> spi_cs
	) else $error("cs low while waiting");

	// flag must be up before the first rising sck
	a_sck_gated: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		!spi_clocking |-> !spi_sck
	) else $error("sck running with clocking flag clear");

	a_idx_range: assert property (
		@(posedge CLK50MHZ) disable iff (RST)
		bit_idx <= SPI_IDX_W'(SPI_WIDTH)
	) else $error("bit counter past frame length");

endmodule

// ==== source/spi_pkg.sv ====
package spi_pkg;

	//////////////////////////////
	// frame and serial clock timing
	//////////////////////////////

	// bits per frame
	localparam int SPI_WIDTH = 32;
	// bit counter width, must hold SPI_WIDTH itself
	localparam int SPI_IDX_W = 6;
	// CLK50MHZ cycles per half period of sck
	localparam int SCK_HALF_CYCLES = 4;
	localparam int SCK_CNT_W = $clog2(SCK_HALF_CYCLES);
	// sck held low while cs is high
	localparam bit SCK_GATED = 1'b1;

	// op codes of the command word
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_READ = 4'h2;

	// shift engine states
	localparam logic [1:0] M_WAIT = 2'd0;
	localparam logic [1:0] M_SEND = 2'd1;
	localparam logic [1:0] M_DONE = 2'd2;

	// frame controller states
	localparam logic [1:0] C_IDLE = 2'd0;
	localparam logic [1:0] C_RUN = 2'd1;
	localparam logic [1:0] C_REPORT = 2'd2;

	//////////////////////////////
	// word layouts, msb first on the wire
	//////////////////////////////

	// outgoing view
	typedef struct packed {
		logic [3:0] op;
		logic [3:0] channel;
		logic [15:0] code;
		logic [7:0] pad;
	} cmd_word_t;

	// incoming view
	typedef struct packed {
		logic [3:0] status;
		logic [3:0] channel;
		logic [15:0] sample;
		logic [7:0] tag;
	} reply_word_t;

	// one shift register, two readings
	typedef union packed {
		cmd_word_t cmd;
		reply_word_t reply;
	} spi_word_u;

	// request from the user side
	typedef struct packed {
		logic write;
		logic [1:0] channel;
		logic [15:0] code;
	} conv_req_t;

	// decoded reply
	typedef struct packed {
		logic [3:0] channel;
		logic [15:0] sample;
		logic [3:0] status;
		logic chan_match;
		logic was_write;
	} conv_result_t;

endpackage

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
	output logic CLK50MHZ,
	output logic RST
);

	// 20 ns period
	initial begin
		CLK50MHZ = 1'b0;
		forever begin
			#10 CLK50MHZ = ~CLK50MHZ;
		end
	end

	// high for 8 rising edges, dropped just after the last one
	initial begin
		RST = 1'b1;
		repeat (8) @(posedge CLK50MHZ);
		#1 RST = 1'b0;
	end

endmodule

// ==== test/tb_conv_spi.sv ====
`timescale 1ns/10ps

module tb_conv_spi import spi_pkg::*; ();

	localparam int N_REQ = 40;
	localparam int RESET_TIMEOUT = 20;
	// about 34 bit periods of 8 cycles, with margin
	localparam int FRAME_TIMEOUT = 400;

	logic CLK50MHZ;
	logic RST;
	logic req_valid;
	conv_req_t req;
	logic busy;
	logic result_valid;
	conv_result_t result;
	logic spi_sck;
	logic spi_cs;
	logic spi_mosi;
	logic spi_miso;

	// random source
	logic [31:0] lfsr;
	// slave model state
	logic [31:0] reply_word;
	logic [31:0] mosi_cap;
	int sck_rises;
	logic cs_prev;
	logic sck_prev;
	// both channel match cases must show up
	int match_cnt;
	int mismatch_cnt;

	tb_clk_gen clk_rst (
		.CLK50MHZ (CLK50MHZ),
		.RST (RST)
	);

	conv_spi_top UUT (
		.CLK50MHZ (CLK50MHZ),
		.RST (RST),
		.req_valid (req_valid),
		.req (req),
		.busy (busy),
		.result_valid (result_valid),
		.result (result),
		.spi_sck (spi_sck),
		.spi_cs (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	//////////////////////////////
	// random bits
	//////////////////////////////
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	//////////////////////////////
	// error reporting
	//////////////////////////////
	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic plain_error(input string what);
		$display("error at t=%0t: %s", $time, what);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else value_error(name, got, exp);
	endtask

	// no frame, no request in flight
	task automatic check_idle();
		check_value("spi_cs", spi_cs, 1);
		check_value("spi_sck", spi_sck, 0);
		check_value("spi_mosi", spi_mosi, 0);
		check_value("busy", busy, 0);
		check_value("result_valid", result_valid, 0);
	endtask

	//////////////////////////////
	// clock step and slave model
	//////////////////////////////
	// pins read and miso driven 1 ns after the edge
	task automatic clock_step();
		@(posedge CLK50MHZ);
		#1;
		// cs falling, reply msb goes out
		if (cs_prev && !spi_cs) begin
			spi_miso = reply_word[31];
			mosi_cap = '0;
			sck_rises = 0;
		end
		if (!spi_cs && spi_sck && !sck_prev) begin
			mosi_cap = {mosi_cap[30:0], spi_mosi};
			sck_rises++;
			// master samples a full bit after the first rise,
			// so the msb is held across two rises
			if (sck_rises >= 2 && sck_rises <= 32) begin
				spi_miso = reply_word[32 - sck_rises];
			end
		end
		if (spi_cs) begin
			spi_miso = 1'b0;
			check_value("spi_sck", spi_sck, 0);
		end
		cs_prev = spi_cs;
		sck_prev = spi_sck;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		conv_req_t r;
		logic [31:0] bits;
		logic [31:0] exp_cmd;
		conv_result_t exp_res;
		int n;

		req_valid = 1'b0;
		req = '0;
		spi_miso = 1'b0;
		lfsr = 32'hba17;
		reply_word = '0;
		mosi_cap = '0;
		sck_rises = 0;
		cs_prev = 1'b1;
		sck_prev = 1'b0;
		match_cnt = 0;
		mismatch_cnt = 0;

		// reset release, seen on a clock edge
		n = 0;
		@(posedge CLK50MHZ);
		while (RST && n < RESET_TIMEOUT) begin
			@(posedge CLK50MHZ);
			n++;
		end
		if (RST) begin
			plain_error("reset was never released");
		end
		#1;
		cs_prev = spi_cs;
		sck_prev = spi_sck;
		check_idle();

		for (int k = 0; k < N_REQ; k++) begin
			// idle gap, one to eight cycles
			take_bits(3, bits);
			for (int g = 0; g <= bits[2:0]; g++) begin
				clock_step();
				check_idle();
			end

			take_bits(19, bits);
			r = bits[18:0];
			take_bits(32, reply_word);
			// half the replies echo the request channel
			take_bits(4, bits);
			if (bits[0]) begin
				reply_word[27:24] = {2'b00, r.channel};
				match_cnt++;
			end else begin
				reply_word[27:24] = {2'b00, r.channel} ^ {bits[3:1], 1'b1};
				mismatch_cnt++;
			end

			// op 1 for write, 2 for read, channel zero extended, pad zero
			exp_cmd = {(r.write ? 4'h1 : 4'h2), 2'b00, r.channel, r.code, 8'h00};
			exp_res.channel = reply_word[27:24];
			exp_res.sample = reply_word[23:8];
			exp_res.status = reply_word[31:28];
			// the forced case decides the match
			exp_res.chan_match = bits[0];
			exp_res.was_write = r.write;

			// one cycle request pulse
			req = r;
			req_valid = 1'b1;
			clock_step();
			req_valid = 1'b0;
			req = '0;

			n = 0;
			while (!result_valid && n < FRAME_TIMEOUT) begin
				check_value("busy", busy, 1);
				clock_step();
				n++;
			end
			if (!result_valid) begin
				plain_error("timeout waiting for result_valid");
			end

			check_value("busy", busy, 1);
			check_value("spi_cs", spi_cs, 1);
			check_value("sck_rises", sck_rises, 32);
			check_value("mosi_word", mosi_cap, exp_cmd);
			check_value("result.channel", result.channel, exp_res.channel);
			check_value("result.sample", result.sample, exp_res.sample);
			check_value("result.status", result.status, exp_res.status);
			check_value("result.chan_match", result.chan_match, exp_res.chan_match);
			check_value("result.was_write", result.was_write, exp_res.was_write);
		end

		// last pulse must end after one cycle
		clock_step();
		check_idle();

		if (match_cnt == 0 || mismatch_cnt == 0) begin
			plain_error("channel match and mismatch were not both exercised");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
